//--- src/cpu_types_pkg.sv
// Processor types shared by all stages: word widths, MIPS encodings, ALU ops, forwarding selects
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluop_t;

  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_type_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_type_t;

  // Same instruction word seen as R-type or I-type
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

endpackage

//--- src/fetch_stage.sv
// Fetch stage: PC register, next-PC selection and the fetch/decode pipeline register
module fetch_stage #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   ihit,
  input  cpu_types_pkg::word_t   imem_load,
  input  logic                   freeze,
  input  logic                   flush,
  input  logic                   halted,
  input  logic                   branch_taken,
  input  cpu_types_pkg::word_t   branch_addr,
  input  logic                   jump_sel,
  input  cpu_types_pkg::word_t   jump_addr,
  output logic                   imem_ren,
  output cpu_types_pkg::word_t   imem_addr,
  output cpu_types_pkg::instr_u  instr,
  output cpu_types_pkg::word_t   npc
);
  import cpu_types_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;
  logic  redirect;

  assign pc_plus4 = pc + 32'd4;
  assign redirect = branch_taken | jump_sel;
  assign pc_next  = jump_sel ? jump_addr : (branch_taken ? branch_addr : pc_plus4);

  assign imem_ren  = ~halted;
  assign imem_addr = pc;

  // A redirect from decode moves the PC even while the fetch is still waiting
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (!freeze && !halted && (ihit || redirect)) begin
      pc <= pc_next;
    end
  end

  // Bubble into decode on flush, missing hit or halt
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      instr <= '0;
    end else if (!freeze) begin
      if (flush || !ihit || halted) begin
        instr <= '0;
      end else begin
        instr <= imem_load;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze && ihit) begin
      npc <= pc_plus4;
    end
  end

endmodule

//--- src/decode_stage.sv
// Decode stage: register file, control decode, branch and jump resolution, decode/execute register
module decode_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  cpu_types_pkg::instr_u    instr,
  input  cpu_types_pkg::word_t     npc,
  input  logic                     freeze,
  input  logic                     flush,
  input  logic                     wb_wen,
  input  cpu_types_pkg::regbits_t  wb_reg,
  input  cpu_types_pkg::word_t     wb_data,
  output logic                     branch_taken,
  output cpu_types_pkg::word_t     branch_addr,
  output logic                     jump_sel,
  output cpu_types_pkg::word_t     jump_addr,
  output cpu_types_pkg::regbits_t  ex_rs,
  output cpu_types_pkg::regbits_t  ex_rt,
  output cpu_types_pkg::regbits_t  ex_rd,
  output cpu_types_pkg::word_t     ex_a,
  output cpu_types_pkg::word_t     ex_b,
  output cpu_types_pkg::word_t     ex_imm,
  output cpu_types_pkg::aluop_t    ex_aluop,
  output logic                     ex_use_imm,
  output logic                     ex_reg_wen,
  output logic                     ex_dren,
  output logic                     ex_dwen,
  output logic                     ex_halt
);
  import cpu_types_pkg::*;

  word_t    regs [1:31];
  word_t    rs_val;
  word_t    rt_val;
  word_t    imm_ext;
  regbits_t dest;
  aluop_t   aluop;
  logic     use_imm;
  logic     reg_wen;
  logic     dren;
  logic     dwen;
  logic     halt_op;

  always_ff @(posedge CLK) begin
    if (wb_wen && wb_reg != '0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // Write-first read with bypass of the writeback value
  assign rs_val = (instr.i.rs == '0) ? '0 :
                  (wb_wen && wb_reg == instr.i.rs) ? wb_data : regs[instr.i.rs];
  assign rt_val = (instr.i.rt == '0) ? '0 :
                  (wb_wen && wb_reg == instr.i.rt) ? wb_data : regs[instr.i.rt];

  assign branch_addr = npc + {imm_ext[29:0], 2'b00};

  always_comb begin
    dest         = instr.i.rt;
    aluop        = ALU_ADD;
    use_imm      = 1'b1;
    reg_wen      = 1'b0;
    dren         = 1'b0;
    dwen         = 1'b0;
    halt_op      = 1'b0;
    branch_taken = 1'b0;
    jump_sel     = 1'b0;
    imm_ext      = {{16{instr.i.imm[15]}}, instr.i.imm};
    jump_addr    = {npc[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};
    case (instr.r.opcode)
      OP_RTYPE: begin
        dest    = instr.r.rd;
        use_imm = 1'b0;
        reg_wen = 1'b1;
        case (instr.r.funct)
          FN_ADDU: aluop = ALU_ADD;
          FN_SUBU: aluop = ALU_SUB;
          FN_AND:  aluop = ALU_AND;
          FN_OR:   aluop = ALU_OR;
          FN_SLT:  aluop = ALU_SLT;
          // Unknown function codes, and the all-zero bubble, write nothing
          default: reg_wen = 1'b0;
        endcase
      end
      OP_ADDIU: reg_wen = 1'b1;
      OP_ORI: begin
        reg_wen = 1'b1;
        aluop   = ALU_OR;
        imm_ext = {16'h0, instr.i.imm};
      end
      OP_LUI: begin
        reg_wen = 1'b1;
        aluop   = ALU_LUI;
        imm_ext = {16'h0, instr.i.imm};
      end
      OP_LW: begin
        reg_wen = 1'b1;
        dren    = 1'b1;
      end
      OP_SW:  dwen = 1'b1;
      OP_BEQ: branch_taken = (rs_val == rt_val);
      OP_BNE: branch_taken = (rs_val != rt_val);
      OP_J:   jump_sel = 1'b1;
      OP_HALT: begin
        // Spin on the HALT itself so nothing younger enters the pipeline
        halt_op   = 1'b1;
        jump_sel  = 1'b1;
        jump_addr = npc - 32'd4;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_rs      <= '0;
      ex_rt      <= '0;
      ex_rd      <= '0;
      ex_aluop   <= ALU_ADD;
      ex_use_imm <= 1'b0;
      ex_reg_wen <= 1'b0;
      ex_dren    <= 1'b0;
      ex_dwen    <= 1'b0;
      ex_halt    <= 1'b0;
    end else if (!freeze) begin
      if (flush) begin
        ex_rs      <= '0;
        ex_rt      <= '0;
        ex_rd      <= '0;
        ex_reg_wen <= 1'b0;
        ex_dren    <= 1'b0;
        ex_dwen    <= 1'b0;
        ex_halt    <= 1'b0;
      end else begin
        ex_rs      <= instr.i.rs;
        ex_rt      <= instr.i.rt;
        ex_rd      <= dest;
        ex_aluop   <= aluop;
        ex_use_imm <= use_imm;
        ex_reg_wen <= reg_wen;
        ex_dren    <= dren;
        ex_dwen    <= dwen;
        ex_halt    <= halt_op;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      ex_a   <= rs_val;
      ex_b   <= rt_val;
      ex_imm <= imm_ext;
    end
  end

endmodule

//--- src/execute_stage.sv
// Execute stage: operand forwarding, ALU and the execute/memory pipeline register
module execute_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     freeze_all,
  input  cpu_types_pkg::regbits_t  ex_rd,
  input  cpu_types_pkg::word_t     ex_a,
  input  cpu_types_pkg::word_t     ex_b,
  input  cpu_types_pkg::word_t     ex_imm,
  input  cpu_types_pkg::aluop_t    ex_aluop,
  input  logic                     ex_use_imm,
  input  logic                     ex_reg_wen,
  input  logic                     ex_dren,
  input  logic                     ex_dwen,
  input  logic                     ex_halt,
  input  cpu_types_pkg::fwd_sel_t  fwd_a,
  input  cpu_types_pkg::fwd_sel_t  fwd_b,
  input  cpu_types_pkg::word_t     wb_data,
  output cpu_types_pkg::word_t     mem_result,
  output cpu_types_pkg::word_t     mem_store,
  output cpu_types_pkg::regbits_t  mem_rd,
  output logic                     mem_reg_wen,
  output logic                     mem_dren,
  output logic                     mem_dwen,
  output logic                     mem_halt
);
  import cpu_types_pkg::*;

  word_t a_op;
  word_t b_fwd;
  word_t b_op;
  word_t alu_out;

  function automatic word_t pick(input fwd_sel_t sel, input word_t own, input word_t from_mem,
                                 input word_t from_wb);
    case (sel)
      FWD_MEM: return from_mem;
      FWD_WB:  return from_wb;
      default: return own;
    endcase
  endfunction

  // The memory-stage value is this stage's own registered result
  assign a_op  = pick(fwd_a, ex_a, mem_result, wb_data);
  assign b_fwd = pick(fwd_b, ex_b, mem_result, wb_data);
  assign b_op  = ex_use_imm ? ex_imm : b_fwd;

  always_comb begin
    case (ex_aluop)
      ALU_SUB: alu_out = a_op - b_op;
      ALU_AND: alu_out = a_op & b_op;
      ALU_OR:  alu_out = a_op | b_op;
      ALU_SLT: alu_out = {31'b0, $signed(a_op) < $signed(b_op)};
      ALU_LUI: alu_out = {b_op[15:0], 16'h0};
      default: alu_out = a_op + b_op;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_rd      <= '0;
      mem_reg_wen <= 1'b0;
      mem_dren    <= 1'b0;
      mem_dwen    <= 1'b0;
      mem_halt    <= 1'b0;
    end else if (!freeze_all) begin
      mem_rd      <= ex_rd;
      mem_reg_wen <= ex_reg_wen;
      mem_dren    <= ex_dren;
      mem_dwen    <= ex_dwen;
      mem_halt    <= ex_halt;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze_all) begin
      mem_result <= alu_out;
      mem_store  <= b_fwd;
    end
  end

endmodule

//--- src/memory_stage.sv
// Memory stage: data request control and the memory/writeback pipeline register
module memory_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  cpu_types_pkg::word_t     mem_result,
  input  cpu_types_pkg::word_t     mem_store,
  input  cpu_types_pkg::regbits_t  mem_rd,
  input  logic                     mem_reg_wen,
  input  logic                     mem_dren,
  input  logic                     mem_dwen,
  input  logic                     mem_halt,
  input  logic                     dhit,
  input  cpu_types_pkg::word_t     dmem_load,
  output logic                     dmem_ren,
  output logic                     dmem_wen,
  output cpu_types_pkg::word_t     dmem_addr,
  output cpu_types_pkg::word_t     dmem_store,
  output logic                     mem_busy,
  output logic                     wb_sel_load,
  output cpu_types_pkg::word_t     wb_alu,
  output cpu_types_pkg::word_t     wb_load,
  output cpu_types_pkg::regbits_t  wb_reg,
  output logic                     wb_wen,
  output logic                     wb_halt
);

  logic wb_wen_q;

  // Request comes straight from the held execute/memory register
  assign dmem_ren   = mem_dren;
  assign dmem_wen   = mem_dwen;
  assign dmem_addr  = mem_result;
  assign dmem_store = mem_store;
  assign mem_busy   = (mem_dren | mem_dwen) & ~dhit;

  // Register keeps its contents while busy, but the write port sees a bubble
  assign wb_wen = wb_wen_q & ~mem_busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_sel_load <= 1'b0;
      wb_reg      <= '0;
      wb_wen_q    <= 1'b0;
      wb_halt     <= 1'b0;
    end else if (!mem_busy) begin
      wb_sel_load <= mem_dren;
      wb_reg      <= mem_rd;
      wb_wen_q    <= mem_reg_wen;
      wb_halt     <= mem_halt;
    end
  end

  always_ff @(posedge CLK) begin
    if (!mem_busy) begin
      wb_alu  <= mem_result;
      wb_load <= dmem_load;
    end
  end

endmodule

//--- src/hazard_unit.sv
// Hazard unit: load-use stall, memory wait freeze and branch flush control
module hazard_unit (
  input  cpu_types_pkg::instr_u    instr,
  input  logic                     ex_dren,
  input  cpu_types_pkg::regbits_t  ex_rd,
  input  logic                     branch_taken,
  input  logic                     jump_sel,
  input  logic                     mem_busy,
  output logic                     freeze_fd,
  output logic                     flush_fd,
  output logic                     flush_dx,
  output logic                     freeze_all
);

  logic load_use;

  // Load in execute writing a source of the instruction in decode
  assign load_use = ex_dren && (ex_rd != '0) &&
                    (ex_rd == instr.r.rs || ex_rd == instr.r.rt);

  assign freeze_all = mem_busy;
  assign freeze_fd  = load_use | mem_busy;
  assign flush_dx   = load_use & ~mem_busy;

  // A redirect counts only once decode is allowed to move on
  assign flush_fd = (branch_taken | jump_sel) & ~freeze_fd;

endmodule

//--- src/forwarding_unit.sv
// Forwarding unit: picks the execute operand sources from the memory and writeback stages
module forwarding_unit (
  input  cpu_types_pkg::regbits_t  ex_rs,
  input  cpu_types_pkg::regbits_t  ex_rt,
  input  cpu_types_pkg::regbits_t  mem_rd,
  input  logic                     mem_reg_wen,
  input  logic                     mem_dren,
  input  cpu_types_pkg::regbits_t  wb_reg,
  input  logic                     wb_wen,
  output cpu_types_pkg::fwd_sel_t  fwd_a,
  output cpu_types_pkg::fwd_sel_t  fwd_b
);
  import cpu_types_pkg::*;

  logic mem_ok;
  logic wb_ok;

  // Load data is not ready in the memory stage yet
  assign mem_ok = mem_reg_wen && !mem_dren && (mem_rd != '0);
  assign wb_ok  = wb_wen && (wb_reg != '0);

  // Memory stage wins over writeback
  assign fwd_a = (mem_ok && mem_rd == ex_rs) ? FWD_MEM :
                 (wb_ok && wb_reg == ex_rs) ? FWD_WB : FWD_NONE;
  assign fwd_b = (mem_ok && mem_rd == ex_rt) ? FWD_MEM :
                 (wb_ok && wb_reg == ex_rt) ? FWD_WB : FWD_NONE;

endmodule

//--- src/datapath.sv
// Pipelined MIPS datapath top: stage and unit wiring, writeback mux and halt register
module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   ihit,
  input  cpu_types_pkg::word_t   imem_load,
  input  logic                   dhit,
  input  cpu_types_pkg::word_t   dmem_load,
  output logic                   imem_ren,
  output cpu_types_pkg::word_t   imem_addr,
  output logic                   dmem_ren,
  output logic                   dmem_wen,
  output cpu_types_pkg::word_t   dmem_addr,
  output cpu_types_pkg::word_t   dmem_store,
  output logic                   halt
);
  import cpu_types_pkg::*;

  instr_u   instr;
  word_t    npc;
  logic     branch_taken;
  logic     jump_sel;
  word_t    branch_addr;
  word_t    jump_addr;
  regbits_t ex_rs;
  regbits_t ex_rt;
  regbits_t ex_rd;
  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_imm;
  aluop_t   ex_aluop;
  logic     ex_use_imm;
  logic     ex_reg_wen;
  logic     ex_dren;
  logic     ex_dwen;
  logic     ex_halt;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    mem_result;
  word_t    mem_store;
  regbits_t mem_rd;
  logic     mem_reg_wen;
  logic     mem_dren;
  logic     mem_dwen;
  logic     mem_halt;
  logic     mem_busy;
  logic     wb_sel_load;
  word_t    wb_alu;
  word_t    wb_load;
  word_t    wb_data;
  regbits_t wb_reg;
  logic     wb_wen;
  logic     wb_halt;
  logic     freeze_fd;
  logic     flush_fd;
  logic     flush_dx;
  logic     freeze_all;

  fetch_stage #(.PC_INIT(PC_INIT)) fetch_i (
    .CLK, .nRST, .ihit, .imem_load,
    .freeze(freeze_fd), .flush(flush_fd), .halted(halt),
    .branch_taken, .branch_addr, .jump_sel, .jump_addr,
    .imem_ren, .imem_addr, .instr, .npc
  );

  decode_stage decode_i (
    .CLK, .nRST, .instr, .npc,
    .freeze(freeze_all), .flush(flush_dx),
    .wb_wen, .wb_reg, .wb_data,
    .branch_taken, .branch_addr, .jump_sel, .jump_addr,
    .ex_rs, .ex_rt, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_aluop,
    .ex_use_imm, .ex_reg_wen, .ex_dren, .ex_dwen, .ex_halt
  );

  execute_stage execute_i (
    .CLK, .nRST, .freeze_all,
    .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_aluop,
    .ex_use_imm, .ex_reg_wen, .ex_dren, .ex_dwen, .ex_halt,
    .fwd_a, .fwd_b, .wb_data,
    .mem_result, .mem_store, .mem_rd, .mem_reg_wen, .mem_dren, .mem_dwen, .mem_halt
  );

  memory_stage memory_i (
    .CLK, .nRST,
    .mem_result, .mem_store, .mem_rd, .mem_reg_wen, .mem_dren, .mem_dwen, .mem_halt,
    .dhit, .dmem_load,
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .mem_busy,
    .wb_sel_load, .wb_alu, .wb_load, .wb_reg, .wb_wen, .wb_halt
  );

  hazard_unit hazard_i (
    .instr, .ex_dren, .ex_rd, .branch_taken, .jump_sel, .mem_busy,
    .freeze_fd, .flush_fd, .flush_dx, .freeze_all
  );

  forwarding_unit forward_i (
    .ex_rs, .ex_rt, .mem_rd, .mem_reg_wen, .mem_dren, .wb_reg, .wb_wen,
    .fwd_a, .fwd_b
  );

  // Writeback result select
  assign wb_data = wb_sel_load ? wb_load : wb_alu;

  // Sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (wb_halt) begin
      halt <= 1'b1;
    end
  end

endmodule

//--- verif/clock_gen.sv
// Testbench clock and power-on reset: 4 ns clock, reset held low for 16 cycles
module clock_gen (
  output logic CLK,
  output logic por_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    por_n = 1'b0;
    repeat (16) @(posedge CLK);
    #1 por_n = 1'b1;
  end

endmodule

//--- verif/datapath_sva.sv
// Data port handshake and halt assertions, bound into the datapath
module datapath_sva (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  dhit,
  input logic                  dmem_ren,
  input logic                  dmem_wen,
  input cpu_types_pkg::word_t  dmem_addr,
  input cpu_types_pkg::word_t  dmem_store,
  input logic                  halt
);
  timeunit 1ns;
  timeprecision 100ps;

  no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen))
    else $error("data read and write enables high together");

  // Request held until the data side answers
  request_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_ren || dmem_wen) && !dhit |=> $stable(dmem_ren) && $stable(dmem_wen) &&
    $stable(dmem_addr) && $stable(dmem_store))
    else $error("data request changed before dhit");

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt dropped before reset");

endmodule

//--- verif/datapath_tb.sv
// Datapath testbench: memory models, program table with expected stores, timeout
module datapath_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_types_pkg::*;

  localparam int NPROG = 5;
  localparam int NRUNS = 2 * NPROG;
  localparam int LIMIT = 64 * 16 * NRUNS;

  logic  CLK;
  logic  por_n;
  logic  rst_n;
  logic  nRST;
  logic  ihit;
  logic  dhit;
  word_t imem_load;
  word_t dmem_load;
  logic  imem_ren;
  logic  dmem_ren;
  logic  dmem_wen;
  logic  halt;
  word_t imem_addr;
  word_t dmem_addr;
  word_t dmem_store;

  word_t imem [64];
  word_t dmem [64];
  word_t prog [NPROG][16];
  word_t exp_addr [NPROG];
  word_t exp_data [NPROG];
  word_t last_addr;
  word_t last_data;
  int    writes_seen;
  int    run_errors;
  int    cycles;
  int    passes;
  int    fails;
  logic  rand_hits;

  assign nRST = por_n & rst_n;

  clock_gen clock_i (.CLK, .por_n);

  datapath datapath_i (
    .CLK, .nRST, .ihit, .imem_load, .dhit, .dmem_load,
    .imem_ren, .imem_addr, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt
  );

  bind datapath datapath_sva sva_i (
    .CLK, .nRST, .dhit, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt
  );

  function automatic word_t r_op(funct_t fn, int rs, int rt, int rd);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic word_t i_op(opcode_t op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic word_t j_op(int index);
    return {OP_J, 26'(index)};
  endfunction

  // Programs and the final store each one should make
  task automatic build_table();
    for (int p = 0; p < NPROG; p++) begin
      for (int k = 0; k < 16; k++) begin
        prog[p][k] = '0;
      end
    end
    // ADDIU, LUI, ORI, ADDU
    prog[0][0] = i_op(OP_ADDIU, 0, 1, 16'h0123);
    prog[0][1] = i_op(OP_LUI, 0, 2, 16'h4500);
    prog[0][2] = i_op(OP_ORI, 2, 3, 16'h0067);
    prog[0][3] = r_op(FN_ADDU, 3, 1, 4);
    prog[0][4] = i_op(OP_SW, 0, 4, 16'h0040);
    prog[0][5] = {OP_HALT, 26'd0};
    exp_addr[0] = 32'h40;
    exp_data[0] = 32'h4500_018a;
    // SUBU, AND, OR, SLT with a negative operand
    prog[1][0] = i_op(OP_ADDIU, 0, 1, 16'h00f0);
    prog[1][1] = i_op(OP_ADDIU, 0, 2, 16'h003c);
    prog[1][2] = r_op(FN_SUBU, 1, 2, 3);
    prog[1][3] = r_op(FN_AND, 3, 1, 4);
    prog[1][4] = r_op(FN_OR, 4, 2, 5);
    prog[1][5] = r_op(FN_SLT, 2, 1, 6);
    prog[1][6] = i_op(OP_ADDIU, 0, 8, 16'hffff);
    prog[1][7] = r_op(FN_SLT, 8, 2, 9);
    prog[1][8] = r_op(FN_SLT, 2, 8, 10);
    prog[1][9] = r_op(FN_ADDU, 5, 6, 7);
    prog[1][10] = r_op(FN_ADDU, 7, 9, 7);
    prog[1][11] = r_op(FN_ADDU, 7, 10, 7);
    prog[1][12] = i_op(OP_SW, 0, 7, 16'h0044);
    prog[1][13] = {OP_HALT, 26'd0};
    exp_addr[1] = 32'h44;
    exp_data[1] = 32'h0000_00be;
    // Dependent chain, sources from memory and writeback stages
    prog[2][0] = i_op(OP_ADDIU, 0, 1, 16'h0001);
    prog[2][1] = r_op(FN_ADDU, 1, 1, 2);
    prog[2][2] = r_op(FN_ADDU, 2, 1, 3);
    prog[2][3] = r_op(FN_ADDU, 3, 2, 4);
    prog[2][4] = r_op(FN_ADDU, 4, 3, 5);
    prog[2][5] = i_op(OP_SW, 0, 5, 16'h0048);
    prog[2][6] = {OP_HALT, 26'd0};
    exp_addr[2] = 32'h48;
    exp_data[2] = 32'h0000_0008;
    // Load then immediate use
    prog[3][0] = i_op(OP_ADDIU, 0, 2, 16'h0011);
    prog[3][1] = i_op(OP_LW, 0, 1, 16'h0010);
    prog[3][2] = r_op(FN_ADDU, 1, 2, 3);
    prog[3][3] = i_op(OP_SW, 0, 3, 16'h004c);
    prog[3][4] = {OP_HALT, 26'd0};
    exp_addr[3] = 32'h4c;
    exp_data[3] = 32'hd004_0415;
    // Branches taken and not taken, then a jump over a clobber
    prog[4][0] = i_op(OP_ADDIU, 0, 1, 16'h0005);
    prog[4][1] = i_op(OP_ADDIU, 0, 2, 16'h0005);
    prog[4][2] = i_op(OP_ADDIU, 0, 3, 16'h0010);
    prog[4][3] = i_op(OP_ADDIU, 0, 5, 16'h0000);
    prog[4][4] = i_op(OP_BEQ, 1, 2, 16'h0001);
    prog[4][5] = i_op(OP_ADDIU, 0, 1, 16'h0077);
    prog[4][6] = i_op(OP_BNE, 1, 2, 16'h0001);
    prog[4][7] = i_op(OP_BNE, 3, 2, 16'h0001);
    prog[4][8] = i_op(OP_ADDIU, 0, 3, 16'h0099);
    prog[4][9] = i_op(OP_BEQ, 3, 2, 16'h0001);
    prog[4][10] = r_op(FN_ADDU, 1, 3, 4);
    prog[4][11] = j_op(13);
    prog[4][12] = i_op(OP_ADDIU, 0, 4, 16'h0055);
    prog[4][13] = i_op(OP_SW, 0, 4, 16'h0050);
    prog[4][14] = {OP_HALT, 26'd0};
    exp_addr[4] = 32'h50;
    exp_data[4] = 32'h0000_0015;
  endtask

  // Memory answers, driven just after the rising edge
  always @(posedge CLK) begin
    #1;
    ihit      = imem_ren && (!rand_hits || ($urandom % 4) != 0);
    imem_load = imem[imem_addr[7:2]];
    dhit      = (dmem_ren || dmem_wen) && (!rand_hits || ($urandom % 4) != 0);
    dmem_load = dmem[dmem_addr[7:2]];
  end

  // Writes and halt behavior sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      if (dmem_wen && dhit) begin
        dmem[dmem_addr[7:2]] = dmem_store;
        last_addr   = dmem_addr;
        last_data   = dmem_store;
        writes_seen = writes_seen + 1;
        if (halt) begin
          $display("data write to %h after halt at %0t", dmem_addr, $time);
          run_errors = run_errors + 1;
        end
      end
      if (halt && imem_ren) begin
        $display("instruction read still enabled after halt at %0t", $time);
        run_errors = run_errors + 1;
      end
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the DUT did not halt within %0d cycles", LIMIT);
      $display("test failed");
      $finish;
    end
  end

  task automatic start_run(input int p);
    @(posedge CLK);
    #1 rst_n = 1'b0;
    for (int k = 0; k < 64; k++) begin
      imem[k] = (k < 16) ? prog[p][k] : '0;
      // Fill depends on the whole word index
      dmem[k] = 32'hd000_0000 + 32'(k) * 32'h0001_0101;
    end
    writes_seen = 0;
    run_errors  = 0;
    repeat (16) @(posedge CLK);
    #1 rst_n = 1'b1;
  endtask

  initial begin
    int p;
    void'($urandom(32'he658_18eb));
    rst_n       = 1'b1;
    ihit        = 1'b0;
    dhit        = 1'b0;
    imem_load   = '0;
    dmem_load   = '0;
    rand_hits   = 1'b0;
    cycles      = 0;
    passes      = 0;
    fails       = 0;
    writes_seen = 0;
    run_errors  = 0;
    last_addr   = '0;
    last_data   = '0;
    build_table();
    wait (por_n);
    for (int run = 0; run < NRUNS; run++) begin
      p         = run % NPROG;
      rand_hits = (run >= NPROG);
      start_run(p);
      while (!halt) begin
        @(posedge CLK);
        #1;
      end
      repeat (4) @(posedge CLK);
      #1;
      if (!halt) begin
        $display("halt fell after rising in program %0d", p);
        run_errors = run_errors + 1;
      end
      if (writes_seen == 0) begin
        $display("program %0d made no data write", p);
        run_errors = run_errors + 1;
      end else if (last_addr != exp_addr[p] || last_data != exp_data[p]) begin
        $display("mismatch at %0t: program %0d stored %h to %h, expected %h to %h",
                 $time, p, last_data, last_addr, exp_data[p], exp_addr[p]);
        run_errors = run_errors + 1;
      end
      if (run_errors == 0) begin
        passes = passes + 1;
        $display("program %0d, %s hits: ok", p, rand_hits ? "random" : "immediate");
      end else begin
        fails = fails + 1;
        $display("program %0d, %s hits: %0d errors", p,
                 rand_hits ? "random" : "immediate", run_errors);
      end
    end
    $display("passed %0d, failed %0d", passes, fails);
    if (fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
src/cpu_types_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/forwarding_unit.sv
src/datapath.sv
verif/clock_gen.sv
verif/datapath_sva.sv
verif/datapath_tb.sv

//--- run.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module datapath_tb -f files.f -o datapath_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/datapath_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
